/* design/pwo_pkg.sv */
// Point-wise engine shared definitions

package pwo_pkg;

    // ========================================
    // Coefficient and memory geometry
    // ========================================
    localparam int COEFF_WIDTH    = 23;
    localparam int SLOT_WIDTH     = 24;
    localparam int COEFF_PER_CLK  = 4;
    localparam int MEM_DATA_WIDTH = SLOT_WIDTH * COEFF_PER_CLK;
    localparam int MEM_ADDR_WIDTH = 15;
    localparam int POLY_ROWS      = 64;

    // Read request to write strobe, in cycles
    localparam int PIPE_DEPTH = 5;

    // q = 2^23 - 2^13 + 1, so 2^23 folds to 2^PWO_Q_K - 1
    localparam int PWO_Q_K = 13;

    // ========================================
    // Types
    // ========================================
    typedef logic [COEFF_WIDTH-1:0]       coeff_t;
    typedef logic [2*COEFF_WIDTH-1:0]     prod_t;
    typedef logic [MEM_DATA_WIDTH-1:0]    mem_data_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]    mem_addr_t;
    typedef logic [$clog2(POLY_ROWS)-1:0] row_cnt_t;

    localparam coeff_t PWO_Q = 23'd8380417;

    typedef enum logic [1:0] {
        op_pwm = 2'd0,
        op_pwa = 2'd1,
        op_pws = 2'd2
    } pwo_op_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_read  = 2'd1,
        st_drain = 2'd2
    } ctrl_state_t;

endpackage

/* design/pwo_modmul.sv */
// Modular multiplier, two-cycle latency

`timescale 1ns/1ps

module pwo_modmul import pwo_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a_i,
    input  coeff_t b_i,
    output coeff_t prod_o
);

    prod_t  prod_q;
    prod_t  fold_1;
    prod_t  fold_2;
    prod_t  fold_3;
    prod_t  red_w;
    coeff_t red_q;

    // One fold of the upper bits: hi*2^23 becomes hi*2^13 - hi
    // Adding q keeps it non-negative, hi stays below q for reduced inputs
    function automatic prod_t fold(input prod_t x);
        prod_t hi;
        prod_t lo;
        hi = x >> COEFF_WIDTH;
        lo = prod_t'(x[COEFF_WIDTH-1:0]);
        return lo + (hi << PWO_Q_K) + prod_t'(PWO_Q) - hi;
    endfunction

    // Three folds leave the product between q and 3q
    always_comb begin
        fold_1 = fold(prod_q);
        fold_2 = fold(fold_1);
        fold_3 = fold(fold_2);
        if (fold_3 >= (prod_t'(PWO_Q) << 1)) begin
            red_w = fold_3 - (prod_t'(PWO_Q) << 1);
        end else begin
            red_w = fold_3 - prod_t'(PWO_Q);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            red_q  <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            red_q  <= '0;
        end else begin
            prod_q <= prod_t'(a_i) * prod_t'(b_i);
            red_q  <= red_w[COEFF_WIDTH-1:0];
        end
    end

    assign prod_o = red_q;

endmodule

/* design/pwo_lane.sv */
// Single coefficient lane

`timescale 1ns/1ps

module pwo_lane import pwo_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    zeroize_i,
    input  pwo_op_t op_i,
    input  logic    accumulate_i,
    input  coeff_t  a_i,
    input  coeff_t  b_i,
    input  coeff_t  c_i,
    output coeff_t  res_o
);

    coeff_t prod;
    coeff_t c_d1, c_d2;
    coeff_t as_d1, as_d2;
    coeff_t res_q;

    function automatic coeff_t add_mod(input coeff_t x, input coeff_t y);
        logic [COEFF_WIDTH:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, PWO_Q}) begin
            s = s - {1'b0, PWO_Q};
        end
        return s[COEFF_WIDTH-1:0];
    endfunction

    function automatic coeff_t sub_mod(input coeff_t x, input coeff_t y);
        logic [COEFF_WIDTH:0] d;
        d = {1'b0, x} - {1'b0, y};
        // Borrow, wrap back into range
        if (x < y) begin
            d = d + {1'b0, PWO_Q};
        end
        return d[COEFF_WIDTH-1:0];
    endfunction

    pwo_modmul mul0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .prod_o    (prod)
    );

    // Add/sub and accumulate operand ride alongside the multiplier
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_d1  <= '0;
            c_d2  <= '0;
            as_d1 <= '0;
            as_d2 <= '0;
            res_q <= '0;
        end else if (zeroize_i) begin
            c_d1  <= '0;
            c_d2  <= '0;
            as_d1 <= '0;
            as_d2 <= '0;
            res_q <= '0;
        end else begin
            c_d1  <= accumulate_i ? c_i : '0;
            c_d2  <= c_d1;
            as_d1 <= (op_i == op_pws) ? sub_mod(a_i, b_i) : add_mod(a_i, b_i);
            as_d2 <= as_d1;
            res_q <= (op_i == op_pwm) ? add_mod(prod, c_d2) : as_d2;
        end
    end

    assign res_o = res_q;

endmodule

/* design/pwo_datapath.sv */
// Four-lane point-wise datapath

`timescale 1ns/1ps

module pwo_datapath import pwo_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  pwo_op_t   op_i,
    input  logic      accumulate_i,
    input  mem_data_t a_data_i,
    input  mem_data_t b_data_i,
    input  mem_data_t c_data_i,
    output mem_data_t wr_data_o
);

    mem_data_t a_q, b_q, c_q;
    coeff_t    res [COEFF_PER_CLK];

    // ========================================
    // Input capture, one cycle after the read
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else if (zeroize_i) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else begin
            a_q <= a_data_i;
            b_q <= b_data_i;
            c_q <= c_data_i;
        end
    end

    // ========================================
    // Lanes, coefficient 0 in the lowest slot
    // ========================================
    for (genvar i = 0; i < COEFF_PER_CLK; i++) begin : g_lane
        pwo_lane lane (
            .clk          (clk),
            .reset_n      (reset_n),
            .zeroize_i    (zeroize_i),
            .op_i         (op_i),
            .accumulate_i (accumulate_i),
            .a_i          (a_q[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .b_i          (b_q[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .c_i          (c_q[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .res_o        (res[i])
        );

        // Pad bit on top of each slot stays zero
        assign wr_data_o[i*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, res[i]};
    end

endmodule

/* design/pwo_ctrl.sv */
// Point-wise operation controller

`timescale 1ns/1ps

module pwo_ctrl import pwo_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,

    input  logic      start_i,
    input  pwo_op_t   op_i,
    input  logic      accumulate_i,
    input  logic      sampler_valid_i,

    input  mem_addr_t base_a_i,
    input  mem_addr_t base_b_i,
    input  mem_addr_t base_c_i,

    output logic      a_rd_en_o,
    output mem_addr_t a_rd_addr_o,
    output logic      b_rd_en_o,
    output mem_addr_t b_rd_addr_o,
    output logic      c_rd_en_o,
    output mem_addr_t c_rd_addr_o,
    output logic      wr_en_o,
    output mem_addr_t wr_addr_o,

    output logic      busy_o,
    output logic      done_o
);

    ctrl_state_t state, state_nxt;
    row_cnt_t    row_cnt;
    logic        issue;
    logic        last_row;

    // Row tracking through the datapath
    logic [PIPE_DEPTH-1:0] valid_sr;
    row_cnt_t              row_sr [PIPE_DEPTH];

    // A row goes out only while the sampler has data for b
    assign issue    = (state == st_read) && sampler_valid_i;
    assign last_row = (row_cnt == row_cnt_t'(POLY_ROWS - 1));

    // ========================================
    // State machine
    // ========================================
    always_comb begin
        state_nxt = state;
        unique case (state)
            st_idle: begin
                if (start_i) begin
                    state_nxt = st_read;
                end
            end
            st_read: begin
                if (issue && last_row) begin
                    state_nxt = st_drain;
                end
            end
            st_drain: begin
                // Pipeline empty, last row is written
                if (valid_sr == '0) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            row_cnt <= '0;
        end else if (zeroize_i) begin
            state   <= st_idle;
            row_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_idle) begin
                row_cnt <= '0;
            end else if (issue) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Write alignment
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                row_sr[i] <= '0;
            end
        end else if (zeroize_i) begin
            valid_sr <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                row_sr[i] <= '0;
            end
        end else begin
            valid_sr  <= {valid_sr[PIPE_DEPTH-2:0], issue};
            row_sr[0] <= row_cnt;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                row_sr[i] <= row_sr[i-1];
            end
        end
    end

    // Read side
    assign a_rd_en_o   = issue;
    assign b_rd_en_o   = issue;
    assign c_rd_en_o   = issue && (op_i == op_pwm) && accumulate_i;
    assign a_rd_addr_o = base_a_i + mem_addr_t'(row_cnt);
    assign b_rd_addr_o = base_b_i + mem_addr_t'(row_cnt);
    assign c_rd_addr_o = base_c_i + mem_addr_t'(row_cnt);

    // Write side, same row index that was read
    assign wr_en_o   = valid_sr[PIPE_DEPTH-1];
    assign wr_addr_o = base_c_i + mem_addr_t'(row_sr[PIPE_DEPTH-1]);

    assign busy_o = (state != st_idle);
    assign done_o = (state == st_drain) && (valid_sr == '0);

endmodule

/* design/pwo_top.sv */
// Point-wise engine top level

`timescale 1ns/1ps

module pwo_top import pwo_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,

    input  pwo_op_t   mode_i,
    input  logic      pwo_enable_i,
    input  logic      accumulate_i,
    input  logic      sampler_valid_i,

    input  mem_addr_t pwo_base_a_i,
    input  mem_addr_t pwo_base_b_i,
    input  mem_addr_t pwo_base_c_i,

    // Operand a and b memories
    output logic      pwm_a_rd_en_o,
    output mem_addr_t pwm_a_rd_addr_o,
    input  mem_data_t pwm_a_rd_data_i,
    output logic      pwm_b_rd_en_o,
    output mem_addr_t pwm_b_rd_addr_o,
    input  mem_data_t pwm_b_rd_data_i,

    // Destination memory
    output logic      mem_rd_en_o,
    output mem_addr_t mem_rd_addr_o,
    input  mem_data_t mem_rd_data_i,
    output logic      mem_wr_en_o,
    output mem_addr_t mem_wr_addr_o,
    output mem_data_t mem_wr_data_o,

    output logic      busy_o,
    output logic      done_o
);

    pwo_op_t op_q;
    logic    acc_q;

    // Operation register, loaded on an accepted start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q  <= op_pwm;
            acc_q <= 1'b0;
        end else if (zeroize_i) begin
            op_q  <= op_pwm;
            acc_q <= 1'b0;
        end else if (pwo_enable_i && !busy_o) begin
            op_q  <= mode_i;
            acc_q <= accumulate_i;
        end
    end

    pwo_ctrl ctrl0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .start_i         (pwo_enable_i),
        .op_i            (op_q),
        .accumulate_i    (acc_q),
        .sampler_valid_i (sampler_valid_i),
        .base_a_i        (pwo_base_a_i),
        .base_b_i        (pwo_base_b_i),
        .base_c_i        (pwo_base_c_i),
        .a_rd_en_o       (pwm_a_rd_en_o),
        .a_rd_addr_o     (pwm_a_rd_addr_o),
        .b_rd_en_o       (pwm_b_rd_en_o),
        .b_rd_addr_o     (pwm_b_rd_addr_o),
        .c_rd_en_o       (mem_rd_en_o),
        .c_rd_addr_o     (mem_rd_addr_o),
        .wr_en_o         (mem_wr_en_o),
        .wr_addr_o       (mem_wr_addr_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    pwo_datapath dp0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .op_i         (op_q),
        .accumulate_i (acc_q),
        .a_data_i     (pwm_a_rd_data_i),
        .b_data_i     (pwm_b_rd_data_i),
        .c_data_i     (mem_rd_data_i),
        .wr_data_o    (mem_wr_data_o)
    );

endmodule

/* bench/pwo_props.sv */
// Controller protocol assertions

`timescale 1ns/1ps

module pwo_props (
    input logic clk,
    input logic reset_n,
    input logic busy_i,
    input logic done_i,
    input logic wr_en_i,
    input logic a_rd_en_i,
    input logic b_rd_en_i,
    input logic c_rd_en_i
);

    wr_only_busy: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_i |-> busy_i)
        else $error("write strobe while the controller is idle");

    // Single-cycle completion strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else $error("done held for more than one cycle");

    idle_no_read: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_i |-> !(a_rd_en_i || b_rd_en_i || c_rd_en_i))
        else $error("memory read issued while idle");

endmodule

bind pwo_ctrl pwo_props props0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .wr_en_i   (wr_en_o),
    .a_rd_en_i (a_rd_en_o),
    .b_rd_en_i (b_rd_en_o),
    .c_rd_en_i (c_rd_en_o)
);

/* bench/pwo_checker.sv */
// Write port checker for the point-wise engine

`timescale 1ns/1ps

module pwo_checker import pwo_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  pwo_op_t   mode_i,
    input  logic      accumulate_i,
    input  logic      pwo_enable_i,
    input  logic      sampler_valid_i,
    input  mem_addr_t base_a_i,
    input  mem_addr_t base_b_i,
    input  mem_addr_t base_c_i,
    input  logic      a_rd_en_i,
    input  mem_addr_t a_rd_addr_i,
    input  mem_data_t a_rd_data_i,
    input  logic      b_rd_en_i,
    input  mem_addr_t b_rd_addr_i,
    input  mem_data_t b_rd_data_i,
    input  logic      c_rd_en_i,
    input  mem_addr_t c_rd_addr_i,
    input  mem_data_t c_rd_data_i,
    input  logic      wr_en_i,
    input  mem_addr_t wr_addr_i,
    input  mem_data_t wr_data_i,
    input  logic      busy_i,
    input  logic      done_i,
    output int        error_count_o,
    output int        row_count_o
);

    pwo_op_t   op_q;
    logic      acc_q;
    mem_addr_t base_a_q;
    mem_addr_t base_b_q;
    mem_addr_t base_c_q;
    int        rows_issued;
    int        rows_written;
    logic      pend;
    mem_addr_t pend_addr;
    logic      zero_chk;
    logic      final_wr;
    logic      busy_exp;
    mem_data_t exp_data_q [$];
    mem_addr_t exp_addr_q [$];

    // Expected row from the lane rules, all arithmetic in 64 bits
    function automatic mem_data_t expected_row(input pwo_op_t op, input logic acc,
                                               input mem_data_t a, input mem_data_t b,
                                               input mem_data_t c);
        mem_data_t row;
        longint    x;
        longint    y;
        longint    z;
        longint    r;
        row = '0;
        for (int l = 0; l < COEFF_PER_CLK; l++) begin
            x = longint'(a[l*SLOT_WIDTH +: COEFF_WIDTH]);
            y = longint'(b[l*SLOT_WIDTH +: COEFF_WIDTH]);
            z = acc ? longint'(c[l*SLOT_WIDTH +: COEFF_WIDTH]) : longint'(0);
            case (op)
                op_pwa:  r = (x + y) % longint'(PWO_Q);
                op_pws:  r = (x - y + longint'(PWO_Q)) % longint'(PWO_Q);
                default: r = (x * y + z) % longint'(PWO_Q);
            endcase
            row[l*SLOT_WIDTH +: COEFF_WIDTH] = r[COEFF_WIDTH-1:0];
        end
        return row;
    endfunction

    task automatic compare_value(input string name, input mem_data_t got,
                                 input mem_data_t exp);
        if (got !== exp) begin
            $display("Error %s: got %0h, expected %0h", name, got, exp);
            error_count_o++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            error_count_o = 0;
            row_count_o   = 0;
            pend          = 1'b0;
            zero_chk      = 1'b0;
            final_wr      = 1'b0;
            busy_exp      = 1'b0;
            exp_data_q.delete();
            exp_addr_q.delete();
        end else if (zeroize_i) begin
            // Everything in flight is dropped
            exp_data_q.delete();
            exp_addr_q.delete();
            pend     = 1'b0;
            final_wr = 1'b0;
            busy_exp = 1'b0;
            zero_chk = 1'b1;
        end else begin
            if (zero_chk && (busy_i || done_i || a_rd_en_i || b_rd_en_i || c_rd_en_i
                             || wr_en_i)) begin
                $display("Zeroize left busy, done or an enable high");
                error_count_o++;
            end
            zero_chk = 1'b0;

            if (busy_i !== busy_exp) begin
                $display("Error busy_o: got %0h, expected %0h", busy_i, busy_exp);
                error_count_o++;
            end

            // ========================================
            // Completion strobe
            // ========================================
            if (done_i && !final_wr) begin
                $display("done_o pulsed without the final write before it");
                error_count_o++;
            end
            if (final_wr && !done_i) begin
                $display("done_o missing in the cycle after the final write");
                error_count_o++;
            end
            final_wr = 1'b0;
            if (done_i) begin
                busy_exp = 1'b0;
            end

            if (pwo_enable_i && !busy_i) begin
                op_q         = mode_i;
                acc_q        = (mode_i == op_pwm) && accumulate_i;
                base_a_q     = base_a_i;
                base_b_q     = base_b_i;
                base_c_q     = base_c_i;
                rows_issued  = 0;
                rows_written = 0;
                busy_exp     = 1'b1;
            end

            // Data returned for last cycle's read
            if (pend) begin
                exp_data_q.push_back(expected_row(op_q, acc_q, a_rd_data_i, b_rd_data_i,
                                                  c_rd_data_i));
                exp_addr_q.push_back(pend_addr);
                pend = 1'b0;
            end

            // ========================================
            // Read side
            // ========================================
            if (a_rd_en_i || b_rd_en_i) begin
                if (!sampler_valid_i) begin
                    $display("Operand read issued while sampler_valid_i is low");
                    error_count_o++;
                end
                if (!(a_rd_en_i && b_rd_en_i)) begin
                    $display("Operand a and b reads are not issued together");
                    error_count_o++;
                end
                if (c_rd_en_i != acc_q) begin
                    $display("Error mem_rd_en_o: got %0h, expected %0h", c_rd_en_i, acc_q);
                    error_count_o++;
                end
                pend_addr = base_c_q + mem_addr_t'(rows_issued);
                compare_value("pwm_a_rd_addr_o", mem_data_t'(a_rd_addr_i),
                              mem_data_t'(base_a_q + mem_addr_t'(rows_issued)));
                compare_value("pwm_b_rd_addr_o", mem_data_t'(b_rd_addr_i),
                              mem_data_t'(base_b_q + mem_addr_t'(rows_issued)));
                if (c_rd_en_i) begin
                    compare_value("mem_rd_addr_o", mem_data_t'(c_rd_addr_i),
                                  mem_data_t'(pend_addr));
                end
                pend = 1'b1;
                rows_issued++;
            end else if (c_rd_en_i) begin
                $display("Destination read without an operand read");
                error_count_o++;
            end

            // ========================================
            // Write side, rows in issue order
            // ========================================
            if (wr_en_i) begin
                if (exp_addr_q.size() == 0) begin
                    $display("Write to address %0h with no row in flight", wr_addr_i);
                    error_count_o++;
                end else begin
                    compare_value("mem_wr_addr_o", mem_data_t'(wr_addr_i),
                                  mem_data_t'(exp_addr_q.pop_front()));
                    compare_value("mem_wr_data_o", wr_data_i, exp_data_q.pop_front());
                    rows_written++;
                    row_count_o++;
                    final_wr = (rows_written == POLY_ROWS);
                end
            end
        end
    end

endmodule

/* bench/pwo_tb.sv */
// Point-wise engine testbench

`timescale 1ns/1ps

module pwo_tb import pwo_pkg::*; ();

    localparam int        NUM_TESTS       = 6;
    localparam int        CYCLES_PER_TEST = 200;
    localparam int        RESET_CYCLES    = 16;
    localparam int        TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;
    localparam mem_addr_t BASE_A          = 15'h0040;
    localparam mem_addr_t BASE_B          = 15'h0100;
    localparam mem_addr_t BASE_C          = 15'h0a80;

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    pwo_op_t   mode;
    logic      pwo_enable;
    logic      accumulate;
    logic      sampler_valid;
    logic      a_rd_en, b_rd_en, c_rd_en, wr_en;
    mem_addr_t a_rd_addr, b_rd_addr, c_rd_addr, wr_addr;
    mem_data_t a_rd_data = '0;
    mem_data_t b_rd_data = '0;
    // Stale destination data before the first read, must be masked
    mem_data_t c_rd_data = '1;
    mem_data_t wr_data;
    logic      busy, done;
    int        check_errors, rows_checked;
    int        errors_seen = 0;
    int        cycle_cnt = 0;
    logic [31:0] lfsr_state;

    mem_data_t mem_a [POLY_ROWS];
    mem_data_t mem_b [POLY_ROWS];
    mem_data_t mem_c [POLY_ROWS];

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ========================================
    // Memory models, one-cycle read latency
    // ========================================
    always @(posedge clk) begin
        if (a_rd_en) begin
            a_rd_data <= mem_a[a_rd_addr[5:0]];
        end
        if (b_rd_en) begin
            b_rd_data <= mem_b[b_rd_addr[5:0]];
        end
        if (c_rd_en) begin
            c_rd_data <= mem_c[c_rd_addr[5:0]];
        end
        if (wr_en) begin
            mem_c[wr_addr[5:0]] <= wr_data;
        end
    end

    pwo_top dut0 (
        .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize),
        .mode_i (mode), .pwo_enable_i (pwo_enable), .accumulate_i (accumulate),
        .sampler_valid_i (sampler_valid),
        .pwo_base_a_i (BASE_A), .pwo_base_b_i (BASE_B), .pwo_base_c_i (BASE_C),
        .pwm_a_rd_en_o (a_rd_en), .pwm_a_rd_addr_o (a_rd_addr), .pwm_a_rd_data_i (a_rd_data),
        .pwm_b_rd_en_o (b_rd_en), .pwm_b_rd_addr_o (b_rd_addr), .pwm_b_rd_data_i (b_rd_data),
        .mem_rd_en_o (c_rd_en), .mem_rd_addr_o (c_rd_addr), .mem_rd_data_i (c_rd_data),
        .mem_wr_en_o (wr_en), .mem_wr_addr_o (wr_addr), .mem_wr_data_o (wr_data),
        .busy_o (busy), .done_o (done)
    );

    pwo_checker chk0 (
        .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize),
        .mode_i (mode), .accumulate_i (accumulate), .pwo_enable_i (pwo_enable),
        .sampler_valid_i (sampler_valid),
        .base_a_i (BASE_A), .base_b_i (BASE_B), .base_c_i (BASE_C),
        .a_rd_en_i (a_rd_en), .a_rd_addr_i (a_rd_addr), .a_rd_data_i (a_rd_data),
        .b_rd_en_i (b_rd_en), .b_rd_addr_i (b_rd_addr), .b_rd_data_i (b_rd_data),
        .c_rd_en_i (c_rd_en), .c_rd_addr_i (c_rd_addr), .c_rd_data_i (c_rd_data),
        .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .busy_i (busy), .done_i (done),
        .error_count_o (check_errors), .row_count_o (rows_checked)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_coeff(output coeff_t c);
        logic [31:0] r;
        do begin
            draw_bits(COEFF_WIDTH, r);
        end while (r[COEFF_WIDTH-1:0] >= PWO_Q);
        c = r[COEFF_WIDTH-1:0];
    endtask

    task automatic fill_operands();
        coeff_t c;
        for (int r = 0; r < POLY_ROWS; r++) begin
            for (int l = 0; l < COEFF_PER_CLK; l++) begin
                draw_coeff(c);
                mem_a[r][l*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, c};
                draw_coeff(c);
                mem_b[r][l*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, c};
            end
        end
        // Extremes in lane 0 of row 0
        mem_a[0][SLOT_WIDTH-1:0] = '0;
        mem_b[0][SLOT_WIDTH-1:0] = {1'b0, PWO_Q - 23'd1};
    endtask

    task automatic start_op(input pwo_op_t op, input logic acc);
        @(posedge clk);
        mode       <= op;
        accumulate <= acc;
        pwo_enable <= 1'b1;
        @(posedge clk);
        pwo_enable <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (!done);
    endtask

    // Sampler drops out at random cycles until the operation ends
    task automatic wait_done_with_gaps();
        logic [31:0] r;
        do begin
            @(posedge clk);
            draw_bits(1, r);
            sampler_valid <= r[0];
        end while (!done);
        sampler_valid <= 1'b1;
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        @(negedge clk);
        errs = check_errors - errors_seen;
        errors_seen = check_errors;
        if (errs == 0) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errs);
        end
    endtask

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        mode          = op_pwa;
        pwo_enable    = 1'b0;
        accumulate    = 1'b0;
        sampler_valid = 1'b1;
        lfsr_state    = 32'ha398f594;
        fill_operands();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        start_op(op_pwa, 1'b0);
        wait_done();
        report_test(1, "pwa random rows");

        fill_operands();
        start_op(op_pws, 1'b0);
        wait_done();
        report_test(2, "pws with wrap-around");

        fill_operands();
        start_op(op_pwm, 1'b0);
        wait_done();
        report_test(3, "pwm without accumulate");

        // Same operands, adds onto the previous products
        start_op(op_pwm, 1'b1);
        wait_done();
        report_test(4, "pwm with accumulate");

        fill_operands();
        start_op(op_pwm, 1'b1);
        wait_done_with_gaps();
        report_test(5, "pwm with sampler gaps");

        start_op(op_pwa, 1'b0);
        repeat (20) @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (10) @(posedge clk);
        fill_operands();
        start_op(op_pwa, 1'b0);
        wait_done();
        report_test(6, "zeroize then pwa");

        $display("Summary: %0d tests, %0d rows checked, %0d errors",
                 NUM_TESTS, rows_checked, check_errors);
        if (check_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/pwo_pkg.sv
design/pwo_modmul.sv
design/pwo_lane.sv
design/pwo_datapath.sv
design/pwo_ctrl.sv
design/pwo_top.sv
bench/pwo_props.sv
bench/pwo_checker.sv
bench/pwo_tb.sv

/* Makefile */
TOP = pwo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
